/* verif/spim_trace.txt */
# columns: dir (t send, r receive), qpi, lsb_first, bits_m1, word count, words in hex
# bits_m1 is word length minus one; bits above the length are ignored by the engine
# standard send, lengths 8, 13 and 32 in both orders
t 0 0 7 3 a5 3c ff
t 0 1 7 3 a5 01 80
t 0 0 12 2 1abc 0f35
t 0 1 12 2 1555 ffff2aaa
t 0 0 31 2 deadbeef 01234567
t 0 1 31 2 80000001 c3a5965a
# quad send, lengths 16 and 32 in both orders
t 1 0 15 3 1234 abcd 8001
t 1 1 15 2 f00f 5a5a
t 1 0 31 2 89abcdef 76543210
t 1 1 31 2 0badf00d fedcba98
# standard receive in both orders
r 0 0 7 4 96 69 00 ff
r 0 1 7 3 1e e1 3c
r 0 0 12 2 1234 0ace
r 0 1 31 3 cafef00d 12345678 80000000
# quad receive in both orders
r 1 0 15 3 beef 1234 0f0f
r 1 1 15 3 4321 a55a fffe
r 1 0 31 2 13579bdf 2468ace0
r 1 1 7 4 5c c5 00 ff
# single word commands
t 0 1 0 1 1
r 1 1 3 1 9

/* all.f */
+incdir+verilog
verilog/spim_cmd_pkg.sv
verilog/spim_pad_pkg.sv
verilog/spim_word_buf.sv
verilog/spim_cmd_decode.sv
verilog/spim_shift_engine.sv
verilog/spim_rx_assemble.sv
verilog/spim_txrx_top.sv
verif/spim_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the spi master testbench with verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module spim_tb -o spim_sim

sim_out="$(./obj_dir/spim_sim 2>&1 || true)"
echo "$sim_out"

if grep -qx "SIMULATION PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1

/* verif/spim_tb.sv */
// testbench for the spi master shift engine: trace driven commands, spi slave model and checks
`timescale 1ns/100ps
`include "spim_settings.svh"

module spim_tb
  import spim_cmd_pkg::*;
  import spim_pad_pkg::*;
();

  localparam int WAIT_TIMEOUT = 200;
  localparam int CMD_TIMEOUT  = 20000;

  logic                   clk_i;
  logic                   rstn_i;
  spim_cmd_t              cmd_i;
  logic                   cmd_valid_i;
  logic                   cmd_ready_o;
  spim_word_t             tx_data_i;
  logic                   tx_valid_i;
  logic                   tx_ready_o;
  spim_word_t             rx_data_o;
  logic                   rx_valid_o;
  logic                   rx_ready_i;
  logic                   done_o;
  logic                   cfg_cpol_i;
  logic [`SPIM_LANES-1:0] sdi_i;
  spim_pads_t             pads_o;

  // command currently taken from the trace
  logic                    cur_rx;
  logic                    cur_qpi;
  logic                    cur_lsb;
  logic [`SPIM_BITS_W-1:0] cur_bits_m1;
  int                      cur_words;
  int                      cur_beats;
  spim_word_t              exp_words [0:15];
  logic [31:0]             rng_state;

  spim_txrx_top u_dut (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .cmd_i       (cmd_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .tx_data_i   (tx_data_i),
    .tx_valid_i  (tx_valid_i),
    .tx_ready_o  (tx_ready_o),
    .rx_data_o   (rx_data_o),
    .rx_valid_o  (rx_valid_o),
    .rx_ready_i  (rx_ready_i),
    .done_o      (done_o),
    .cfg_cpol_i  (cfg_cpol_i),
    .sdi_i       (sdi_i),
    .pads_o      (pads_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // lowest bus bit carried by beat b of a word
  function automatic int beat_pos(int b);
    int nib;
    if (cur_qpi)
    begin
      nib = cur_lsb ? b : cur_beats - 1 - b;
      return 4 * nib;
    end
    return cur_lsb ? b : int'(cur_bits_m1) - b;
  endfunction

  function automatic spim_word_t length_mask();
    return {`SPIM_WORD_W{1'b1}} >> (`SPIM_WORD_W - 1 - int'(cur_bits_m1));
  endfunction

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(string test, logic [31:0] exp_v, logic [31:0] act_v);
    $display("Fail %s: expected %h, actual %h", test, exp_v, act_v);
    stop_with_failure();
  endtask

  task automatic report_error(string what);
    $display("Error: %s", what);
    stop_with_failure();
  endtask

  // next command line of the trace, comments start with #
  task automatic read_command(int fd, output bit found);
    int          c;
    int          code;
    int          qpi;
    int          lsb;
    int          bits_m1;
    logic [31:0] word_v;
    found = 1'b0;
    c = $fgetc(fd);
    while (c != -1 && !found)
    begin
      if (c == "#")
      begin
        while (c != -1 && c != "\n")
          c = $fgetc(fd);
      end
      else if (c == "t" || c == "r")
      begin
        code = $fscanf(fd, "%d %d %d %d", qpi, lsb, bits_m1, cur_words);
        assert (code == 4) else report_error("malformed command line in the trace");
        assert (cur_words >= 1 && cur_words <= 16 && bits_m1 >= 0 && bits_m1 <= 31)
          else report_error("trace command out of range");
        assert (qpi == 0 || bits_m1 % 4 == 3)
          else report_error("quad trace command with a length that is not whole nibbles");
        cur_rx      = (c == "r");
        cur_qpi     = qpi[0];
        cur_lsb     = lsb[0];
        cur_bits_m1 = bits_m1[`SPIM_BITS_W-1:0];
        cur_beats   = cur_qpi ? (bits_m1 + 1) / 4 : bits_m1 + 1;
        for (int i = 0; i < cur_words; i++)
        begin
          code = $fscanf(fd, "%h", word_v);
          assert (code == 1) else report_error("trace line has fewer words than its count");
          exp_words[i] = word_v;
        end
        found = 1'b1;
      end
      if (!found)
        c = $fgetc(fd);
    end
  endtask

  //////////////////////////////
  // one command
  //////////////////////////////

  task automatic run_command(int idx);
    int          cycles;
    int          tx_sent;
    int          rx_got;
    int          beats_seen;
    int          done_seen;
    int          total_beats;
    int          w;
    int          b;
    int          pos;
    logic        tx_hs;
    logic [31:0] r;
    spim_word_t  rebuilt;
    total_beats = cur_words * cur_beats;
    tx_sent     = 0;
    rx_got      = 0;
    beats_seen  = 0;
    done_seen   = 0;
    tx_hs       = 1'b0;
    rebuilt     = '0;
    cfg_cpol_i  = idx[0];

    cmd_i.dir       = cur_rx ? DIR_RX : DIR_TX;
    cmd_i.qpi       = cur_qpi;
    cmd_i.lsb_first = cur_lsb;
    cmd_i.bits_m1   = cur_bits_m1;
    cmd_i.words_m1  = `SPIM_CNT_W'(cur_words - 1);
    cmd_valid_i     = 1'b1;
    cycles = 0;
    while (!cmd_ready_o)
    begin
      @(negedge clk_i);
      cycles++;
      assert (cycles <= WAIT_TIMEOUT) else report_error("timeout waiting for command ready");
    end
    @(negedge clk_i);
    cmd_valid_i = 1'b0;

    cycles = 0;
    while (done_seen == 0 || tx_sent + rx_got < cur_words || !cmd_ready_o)
    begin
      // transmit stream, valid stays up until the word is taken
      if (tx_hs)
      begin
        tx_sent++;
        tx_valid_i = 1'b0;
      end
      r = rand_next();
      if (!cur_rx && !tx_valid_i && tx_sent < cur_words && r[17:16] != 2'b00)
      begin
        tx_valid_i = 1'b1;
        tx_data_i  = exp_words[tx_sent];
      end
      tx_hs = tx_valid_i && tx_ready_o;

      // receive stream with random back-pressure
      rx_ready_i = r[20:18] > 3'd1;
      if (rx_valid_o && rx_ready_i)
      begin
        assert (cur_rx && rx_got < cur_words)
          else report_error("receive word beyond the command's word count");
        assert (rx_data_o == (exp_words[rx_got] & length_mask()))
          else report_mismatch($sformatf("cmd %0d rx word %0d", idx, rx_got),
                               exp_words[rx_got] & length_mask(), rx_data_o);
        rx_got++;
      end
      if (cur_rx)
        assert (pads_o.oen == 4'hf)
          else report_mismatch($sformatf("cmd %0d rx oen", idx), 32'hf, 32'(pads_o.oen));

      //////////////////////////////
      // slave model
      //////////////////////////////
      w = beats_seen / cur_beats;
      b = beats_seen % cur_beats;
      pos = beat_pos(b);
      if (pads_o.spi_clk != cfg_cpol_i)
      begin
        // second half of a beat, past the leading edge
        assert (beats_seen < total_beats) else report_error("spi clock beat beyond the command");
        if (!cur_rx)
        begin
          assert (w < tx_sent) else report_error("spi clock ran before its transmit word came");
          if (cur_qpi)
          begin
            assert (pads_o.oen == 4'h0)
              else report_mismatch($sformatf("cmd %0d quad oen", idx), 32'h0, 32'(pads_o.oen));
            rebuilt[pos +: 4] = pads_o.sdo;
          end
          else
          begin
            assert ({pads_o.oen, pads_o.sdo[3:1]} == 7'b1110_000)
              else report_mismatch($sformatf("cmd %0d std oen and unused sdo", idx),
                                   32'h70, 32'({pads_o.oen, pads_o.sdo[3:1]}));
            rebuilt[pos] = pads_o.sdo[0];
          end
          if (b == cur_beats - 1)
          begin
            assert (rebuilt == (exp_words[w] & length_mask()))
              else report_mismatch($sformatf("cmd %0d tx word %0d", idx, w),
                                   exp_words[w] & length_mask(), rebuilt);
            rebuilt = '0;
          end
        end
        beats_seen++;
      end
      else if (cur_rx && beats_seen < total_beats)
      begin
        // bits for the next sampling edge, other lanes carry the inverse
        if (cur_qpi)
          sdi_i = exp_words[w][pos +: 4];
        else
          sdi_i = {~exp_words[w][pos], ~exp_words[w][pos], exp_words[w][pos], ~exp_words[w][pos]};
      end

      if (done_o)
      begin
        done_seen++;
        assert (done_seen == 1) else report_error("done pulsed more than once for one command");
        assert (beats_seen == total_beats)
          else report_mismatch($sformatf("cmd %0d beats at done", idx), total_beats, beats_seen);
      end

      @(negedge clk_i);
      cycles++;
      assert (cycles <= CMD_TIMEOUT) else report_error("timeout waiting for the command to end");
    end
    assert (beats_seen == total_beats)
      else report_mismatch($sformatf("cmd %0d beats", idx), total_beats, beats_seen);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int fd;
    int cmd_idx;
    bit found;
    rstn_i      = 1'b0;
    cmd_i       = '0;
    cmd_valid_i = 1'b0;
    tx_data_i   = '0;
    tx_valid_i  = 1'b0;
    rx_ready_i  = 1'b0;
    cfg_cpol_i  = 1'b0;
    sdi_i       = '0;
    rng_state   = 32'd53;

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    // idle pins after reset, in both polarities
    for (int pol = 0; pol < 2; pol++)
    begin
      cfg_cpol_i = pol[0];
      @(negedge clk_i);
      assert (cmd_ready_o == 1'b1) else report_mismatch("reset cmd_ready", 1, 32'(cmd_ready_o));
      assert (pads_o.oen == 4'hf) else report_mismatch("reset oen", 32'hf, 32'(pads_o.oen));
      assert (done_o == 1'b0) else report_mismatch("reset done", 0, 32'(done_o));
      assert (rx_valid_o == 1'b0) else report_mismatch("reset rx_valid", 0, 32'(rx_valid_o));
      assert (pads_o.spi_clk == cfg_cpol_i)
        else report_mismatch("reset spi_clk", 32'(cfg_cpol_i), 32'(pads_o.spi_clk));
    end

    fd = $fopen("verif/spim_trace.txt", "r");
    assert (fd != 0) else report_error("cannot open the trace file verif/spim_trace.txt");
    cmd_idx = 0;
    read_command(fd, found);
    while (found)
    begin
      run_command(cmd_idx);
      cmd_idx++;
      read_command(fd, found);
    end
    $fclose(fd);
    assert (cmd_idx > 0) else report_error("trace file holds no commands");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* verilog/spim_txrx_top.sv */
// spi master shift engine top: command decode, word buffers, shift engine and rx assembly
`timescale 1ns/100ps
`include "spim_settings.svh"

module spim_txrx_top
  import spim_cmd_pkg::*;
  import spim_pad_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  spim_cmd_t              cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  spim_word_t             tx_data_i,
  input  logic                   tx_valid_i,
  output logic                   tx_ready_o,
  output spim_word_t             rx_data_o,
  output logic                   rx_valid_o,
  input  logic                   rx_ready_i,
  output logic                   done_o,
  input  logic                   cfg_cpol_i,
  input  logic [`SPIM_LANES-1:0] sdi_i,
  output spim_pads_t             pads_o
);

  spim_plan_t             plan;
  logic                   plan_valid;
  logic                   cmd_done;
  spim_word_t             tx_word;
  logic                   tx_word_valid;
  logic                   tx_word_ready;
  logic                   rx_beat;
  logic [`SPIM_LANES-1:0] rx_lanes;
  logic                   rx_word_end;
  spim_word_t             rx_word;
  logic                   rx_word_valid;
  logic                   rx_room;

  assign done_o = cmd_done;

  spim_cmd_decode u_cmd_decode (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .cmd_i        (cmd_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_done_i   (cmd_done),
    .plan_o       (plan),
    .plan_valid_o (plan_valid)
  );

  spim_word_buf #(.payload_t(spim_word_t)) u_tx_buf (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_data_i   (tx_data_i),
    .in_valid_i  (tx_valid_i),
    .in_ready_o  (tx_ready_o),
    .out_data_o  (tx_word),
    .out_valid_o (tx_word_valid),
    .out_ready_i (tx_word_ready)
  );

  spim_shift_engine u_shift_engine (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .cfg_cpol_i    (cfg_cpol_i),
    .plan_i        (plan),
    .plan_valid_i  (plan_valid),
    .cmd_done_o    (cmd_done),
    .tx_word_i     (tx_word),
    .tx_valid_i    (tx_word_valid),
    .tx_ready_o    (tx_word_ready),
    .rx_room_i     (rx_room),
    .sdi_i         (sdi_i),
    .rx_beat_o     (rx_beat),
    .rx_lanes_o    (rx_lanes),
    .rx_word_end_o (rx_word_end),
    .pads_o        (pads_o)
  );

  spim_rx_assemble u_rx_assemble (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .plan_i        (plan),
    .rx_beat_i     (rx_beat),
    .rx_lanes_i    (rx_lanes),
    .rx_word_end_i (rx_word_end),
    .word_o        (rx_word),
    .word_valid_o  (rx_word_valid)
  );

  spim_word_buf #(.payload_t(spim_word_t)) u_rx_buf (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_data_i   (rx_word),
    .in_valid_i  (rx_word_valid),
    .in_ready_o  (rx_room),
    .out_data_o  (rx_data_o),
    .out_valid_o (rx_valid_o),
    .out_ready_i (rx_ready_i)
  );

endmodule

/* verilog/spim_rx_assemble.sv */
// receive assembly: shifts sampled lanes into words and hands each finished word on
`timescale 1ns/100ps
`include "spim_settings.svh"

module spim_rx_assemble
  import spim_cmd_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  spim_plan_t             plan_i,
  input  logic                   rx_beat_i,
  input  logic [`SPIM_LANES-1:0] rx_lanes_i,
  input  logic                   rx_word_end_i,
  output spim_word_t             word_o,
  output logic                   word_valid_o
);

  spim_word_t              word_q;
  spim_word_t              word_next;
  spim_word_t              in_bits;
  spim_word_t              lane_mask;
  spim_word_t              len_mask;
  logic [`SPIM_BITS_W-1:0] ins_pos;
  logic [2:0]              step;

  always_comb
  begin
    if (plan_i.qpi)
    begin
      step      = 3'(`SPIM_LANES);
      in_bits   = spim_word_t'(rx_lanes_i);
      lane_mask = spim_word_t'({`SPIM_LANES{1'b1}});
      ins_pos   = plan_i.bits_m1 - `SPIM_BITS_W'(`SPIM_LANES - 1);
    end
    else
    begin
      // standard receive listens on line 1
      step      = 3'd1;
      in_bits   = spim_word_t'(rx_lanes_i[1]);
      lane_mask = spim_word_t'(1'b1);
      ins_pos   = plan_i.bits_m1;
    end

    // lsb-first bits enter at the top of the word and walk down to bit 0
    if (plan_i.lsb_first)
      word_next = ((word_q >> step) & ~(lane_mask << ins_pos)) | (in_bits << ins_pos);
    else
      word_next = (word_q << step) | in_bits;
  end

  // keep only bits_m1 down to 0
  assign len_mask = {`SPIM_WORD_W{1'b1}} >> (`SPIM_BITS_W'(`SPIM_WORD_W - 1) - plan_i.bits_m1);

  always_ff @(posedge clk_i, negedge rstn_i)
  begin
    if (!rstn_i)
      word_q <= '0;
    else if (rx_beat_i)
      word_q <= word_next;
  end

  // finished word goes out with the last beat
  assign word_o       = word_next & len_mask;
  assign word_valid_o = rx_word_end_i;

endmodule

/* verilog/spim_shift_engine.sv */
// shift engine: spi clock, beat and word counting, transmit shifting and pin driving
`timescale 1ns/100ps
`include "spim_settings.svh"

module spim_shift_engine
  import spim_cmd_pkg::*;
  import spim_pad_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   cfg_cpol_i,
  input  spim_plan_t             plan_i,
  input  logic                   plan_valid_i,
  output logic                   cmd_done_o,
  input  spim_word_t             tx_word_i,
  input  logic                   tx_valid_i,
  output logic                   tx_ready_o,
  input  logic                   rx_room_i,
  input  logic [`SPIM_LANES-1:0] sdi_i,
  output logic                   rx_beat_o,
  output logic [`SPIM_LANES-1:0] rx_lanes_o,
  output logic                   rx_word_end_o,
  output spim_pads_t             pads_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_SHIFT
  } eng_state_e;

  eng_state_e              state_q;
  // second half of a beat, spi clock away from idle
  logic                    phase_q;
  logic [`SPIM_BITS_W-1:0] beat_cnt_q;
  logic [`SPIM_CNT_W-1:0]  word_cnt_q;
  logic                    done_q;
  spim_word_t              tx_shift_q;
  logic                    is_tx;
  logic                    beat_end;
  logic                    word_go;
  logic [2:0]              step;
  spim_lane_mode_e         lane_mode;

  assign is_tx    = plan_i.dir == DIR_TX;
  assign beat_end = (state_q == ST_SHIFT) && phase_q;
  assign step     = plan_i.qpi ? 3'(`SPIM_LANES) : 3'd1;

  // a word starts once its data is there or the receive side has room
  assign word_go    = (state_q == ST_WAIT) && (is_tx ? tx_valid_i : rx_room_i);
  assign tx_ready_o = (state_q == ST_WAIT) && is_tx;
  assign cmd_done_o = done_q;

  //////////////////////////////
  // control FSM
  //////////////////////////////

  always_ff @(posedge clk_i, negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      state_q    <= ST_IDLE;
      phase_q    <= 1'b0;
      beat_cnt_q <= '0;
      word_cnt_q <= '0;
      done_q     <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          // the plan is still held while done is high
          if (plan_valid_i && !done_q)
          begin
            word_cnt_q <= plan_i.words_m1;
            state_q    <= ST_WAIT;
          end
        end
        ST_WAIT:
        begin
          if (word_go)
          begin
            beat_cnt_q <= plan_i.beats_m1;
            state_q    <= ST_SHIFT;
          end
        end
        ST_SHIFT:
        begin
          phase_q <= ~phase_q;
          if (phase_q)
          begin
            if (beat_cnt_q != '0)
              beat_cnt_q <= beat_cnt_q - 1'b1;
            else if (word_cnt_q != '0)
            begin
              word_cnt_q <= word_cnt_q - 1'b1;
              state_q    <= ST_WAIT;
            end
            else
            begin
              done_q  <= 1'b1;
              state_q <= ST_IDLE;
            end
          end
        end
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // msb-first words are left aligned on load so the next bits sit at the top
  always_ff @(posedge clk_i)
  begin
    if (word_go && is_tx)
    begin
      if (plan_i.lsb_first)
        tx_shift_q <= tx_word_i;
      else
        tx_shift_q <= tx_word_i << (`SPIM_BITS_W'(`SPIM_WORD_W - 1) - plan_i.bits_m1);
    end
    else if (beat_end && is_tx)
    begin
      if (plan_i.lsb_first)
        tx_shift_q <= tx_shift_q >> step;
      else
        tx_shift_q <= tx_shift_q << step;
    end
  end

  //////////////////////////////
  // pins
  //////////////////////////////

  always_comb
  begin
    if (state_q == ST_IDLE)
      lane_mode = MODE_IDLE;
    else if (!is_tx)
      // receive in either width releases every line
      lane_mode = MODE_QUAD_RX;
    else if (plan_i.qpi)
      lane_mode = MODE_QUAD_TX;
    else
      lane_mode = MODE_STD_TX;
  end

  always_comb
  begin
    pads_o.spi_clk = cfg_cpol_i ^ phase_q;
    case (lane_mode)
      MODE_STD_TX:
      begin
        pads_o.sdo    = '0;
        pads_o.sdo[0] = plan_i.lsb_first ? tx_shift_q[0] : tx_shift_q[`SPIM_WORD_W-1];
        pads_o.oen    = {{(`SPIM_LANES-1){1'b1}}, 1'b0};
      end
      MODE_QUAD_TX:
      begin
        if (plan_i.lsb_first)
          pads_o.sdo = tx_shift_q[`SPIM_LANES-1:0];
        else
          pads_o.sdo = tx_shift_q[`SPIM_WORD_W-1 -: `SPIM_LANES];
        pads_o.oen = '0;
      end
      default:
      begin
        pads_o.sdo = '0;
        pads_o.oen = '1;
      end
    endcase
  end

  // sample on the edge that brings spi clock back to idle
  assign rx_beat_o     = beat_end && !is_tx;
  assign rx_lanes_o    = sdi_i;
  assign rx_word_end_o = rx_beat_o && (beat_cnt_q == '0);

  // the plan stays put for as long as a command runs
  assert property (@(posedge clk_i) disable iff (!rstn_i)
    state_q != ST_IDLE |=> $stable(plan_i));

endmodule

/* verilog/spim_cmd_decode.sv */
// command decode: takes one command at a time and holds its plan until the engine finishes
`timescale 1ns/100ps

module spim_cmd_decode
  import spim_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rstn_i,
  input  spim_cmd_t  cmd_i,
  input  logic       cmd_valid_i,
  output logic       cmd_ready_o,
  input  logic       cmd_done_i,
  output spim_plan_t plan_o,
  output logic       plan_valid_o
);

  logic       held_q;
  spim_plan_t plan_q;
  logic       cmd_take;
  logic [$bits(cmd_i.bits_m1)-1:0] beats_m1;

  assign cmd_ready_o  = !held_q;
  assign cmd_take     = cmd_valid_i && cmd_ready_o;
  assign plan_o       = plan_q;
  assign plan_valid_o = held_q;

  // quad moves four bits per beat, standard moves one
  always_comb
  begin
    if (cmd_i.qpi)
      beats_m1 = cmd_i.bits_m1 >> 2;
    else
      beats_m1 = cmd_i.bits_m1;
  end

  always_ff @(posedge clk_i, negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      held_q <= 1'b0;
      plan_q <= '0;
    end
    else
    begin
      if (cmd_take)
      begin
        held_q           <= 1'b1;
        plan_q.dir       <= cmd_i.dir;
        plan_q.qpi       <= cmd_i.qpi;
        plan_q.lsb_first <= cmd_i.lsb_first;
        plan_q.bits_m1   <= cmd_i.bits_m1;
        plan_q.words_m1  <= cmd_i.words_m1;
        plan_q.beats_m1  <= beats_m1;
      end
      else if (cmd_done_i)
        held_q <= 1'b0;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // quad words are whole nibbles
  assert property (@(posedge clk_i) disable iff (!rstn_i)
    cmd_take && cmd_i.qpi |-> cmd_i.bits_m1[1:0] == 2'b11);

  // the engine only finishes a command that is held here
  assert property (@(posedge clk_i) disable iff (!rstn_i)
    cmd_done_i |-> held_q);

endmodule

/* verilog/spim_word_buf.sv */
// one-entry valid/ready word buffer, shared by the transmit and receive streams
`timescale 1ns/100ps

module spim_word_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  payload_t data_q;
  logic     full_q;
  logic     push;

  // room when empty or when the held entry leaves this cycle
  assign in_ready_o  = !full_q || out_ready_i;
  assign push        = in_valid_i && in_ready_o;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i, negedge rstn_i)
  begin
    if (!rstn_i)
      full_q <= 1'b0;
    else if (push)
      full_q <= 1'b1;
    else if (out_ready_i)
      full_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      data_q <= in_data_i;
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // an entry offered to a full buffer stays offered and unchanged until it is taken
  assert property (@(posedge clk_i) disable iff (!rstn_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i));

endmodule

/* verilog/spim_pad_pkg.sv */
// spi master pin types: pad bundle and data lane modes
`include "spim_settings.svh"

package spim_pad_pkg;

  // which data lines the master drives
  typedef enum logic [1:0] {
    MODE_IDLE    = 2'b00,
    MODE_STD_TX  = 2'b01,
    MODE_QUAD_TX = 2'b10,
    MODE_QUAD_RX = 2'b11
  } spim_lane_mode_e;

  // everything that leaves the master towards the pads
  typedef struct packed {
    logic                   spi_clk;
    logic [`SPIM_LANES-1:0] sdo;
    // 1 means the line is released
    logic [`SPIM_LANES-1:0] oen;
  } spim_pads_t;

endpackage

/* verilog/spim_cmd_pkg.sv */
// spi master command types: direction, raw command and the decoded plan
`include "spim_settings.svh"

package spim_cmd_pkg;

  // transfer direction of a whole command
  typedef enum logic {
    DIR_TX = 1'b0,
    DIR_RX = 1'b1
  } spim_dir_e;

  typedef logic [`SPIM_WORD_W-1:0] spim_word_t;

  // command as it arrives on the command stream
  typedef struct packed {
    spim_dir_e               dir;
    logic                    qpi;
    logic                    lsb_first;
    logic [`SPIM_BITS_W-1:0] bits_m1;
    logic [`SPIM_CNT_W-1:0]  words_m1;
  } spim_cmd_t;

  // registered command plus the beat count per word
  typedef struct packed {
    spim_dir_e               dir;
    logic                    qpi;
    logic                    lsb_first;
    logic [`SPIM_BITS_W-1:0] bits_m1;
    logic [`SPIM_CNT_W-1:0]  words_m1;
    logic [`SPIM_BITS_W-1:0] beats_m1;
  } spim_plan_t;

endpackage

/* verilog/spim_settings.svh */
// spi master engine settings: bus word, word count, bit length and lane widths
`ifndef SPIM_SETTINGS_SVH
`define SPIM_SETTINGS_SVH

//////////////////////////////
// data path
//////////////////////////////

// width of one bus word and of the shift registers
`define SPIM_WORD_W 32

// number of data lines in quad mode
`define SPIM_LANES 4

//////////////////////////////
// command fields
//////////////////////////////

// words per command, minus one
`define SPIM_CNT_W 16
// word length minus one, up to 31
`define SPIM_BITS_W 5

`endif
